//--- sim.f
rtl/sync_link_pkg.sv
rtl/link_serializer.sv
rtl/link_deserializer.sv
rtl/handshake_timer.sv
rtl/sync_protocol_fsm.sv
rtl/sync_link_top.sv
sim/tb_sync_link.sv

//--- Makefile
# Verilator build and run of the two-board sync link testbench.

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   list these targets"

test:
	verilator --binary --timing --timescale 1ns/10ps -j 0 \
	  --top-module tb_sync_link -f sim.f
	@out="$$(./obj_dir/Vtb_sync_link)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "No errors"

clean:
	rm -rf obj_dir

//--- sim/tb_sync_link.sv
`timescale 1ns/10ps
`default_nettype none

module tb_sync_link;

  typedef struct packed {
    logic                     rqst;
    sync_link_pkg::cmd_addr_t addr;
    sync_link_pkg::cmd_data_t data;
  } cmd_bus_t;

  // cycle budgets of the six tests, summed for the watchdog.
  localparam int RUN_CYCLES = 60 + 60 + 200 + 200 + 150 + 250;

  logic                      clk;
  logic                      arst_n;
  cmd_bus_t                  bus [2];
  sync_link_pkg::link_pair_t tx_w [2];
  logic [1:0]                stall_req_w;
  logic [1:0]                stall_ack_r;
  logic [1:0]                rst_all_w;
  logic [1:0]                rst_nco_w;
  logic [1:0]                timeout_w;
  logic [1:0]                hold_ack;
  int                        ack_delay [2];
  int                        nco_cnt [2];
  int                        all_cnt [2];
  int                        to_cnt [2];
  int                        stall_cnt [2];
  int                        tx_cnt [2];
  int                        base_nco [2];
  int                        base_all [2];
  int                        base_to [2];
  int                        base_stall [2];
  int                        base_tx [2];
  int                        errors;
  int                        tests;

  // the two boards are cross-wired, each one's linktx feeding the other's linkrx.
  sync_link_top uut (
    .clk       (clk),
    .arst_n    (arst_n),
    .cmd_rqst  (bus[0].rqst),
    .cmd_addr  (bus[0].addr),
    .cmd_data  (bus[0].data),
    .linkrx    (tx_w[1]),
    .linktx    (tx_w[0]),
    .stall_req (stall_req_w[0]),
    .stall_ack (stall_ack_r[0]),
    .rst_all   (rst_all_w[0]),
    .rst_nco   (rst_nco_w[0]),
    .timeout   (timeout_w[0])
  );

  sync_link_top peer (
    .clk       (clk),
    .arst_n    (arst_n),
    .cmd_rqst  (bus[1].rqst),
    .cmd_addr  (bus[1].addr),
    .cmd_data  (bus[1].data),
    .linkrx    (tx_w[0]),
    .linktx    (tx_w[1]),
    .stall_req (stall_req_w[1]),
    .stall_ack (stall_ack_r[1]),
    .rst_all   (rst_all_w[1]),
    .rst_nco   (rst_nco_w[1]),
    .timeout   (timeout_w[1])
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // models the local logic of each board, which grants the stall after a delay.
  initial begin
    int wait_n [2];
    stall_ack_r = 2'b00;
    wait_n[0] = 0;
    wait_n[1] = 0;
    forever begin
      @(negedge clk);
      for (int b = 0; b < 2; b++) begin
        if (stall_req_w[b] !== 1'b1 || hold_ack[b]) begin
          stall_ack_r[b] = 1'b0;
          wait_n[b] = 0;
        end else if (wait_n[b] >= ack_delay[b]) begin
          stall_ack_r[b] = 1'b1;
        end else begin
          wait_n[b]++;
        end
      end
    end
  end

  // counts output pulses and busy cycles on both boards.
  initial begin
    for (int b = 0; b < 2; b++) begin
      nco_cnt[b] = 0;
      all_cnt[b] = 0;
      to_cnt[b] = 0;
      stall_cnt[b] = 0;
      tx_cnt[b] = 0;
    end
    forever begin
      @(posedge clk);
      for (int b = 0; b < 2; b++) begin
        if (rst_nco_w[b] === 1'b1) nco_cnt[b]++;
        if (rst_all_w[b] === 1'b1) all_cnt[b]++;
        if (timeout_w[b] === 1'b1) to_cnt[b]++;
        if (stall_req_w[b] === 1'b1) stall_cnt[b]++;
        if (tx_w[b] !== 2'b00) tx_cnt[b]++;
      end
    end
  end

  initial begin
    repeat (RUN_CYCLES + 200) @(posedge clk);
    $display("watchdog: the run went past %0d cycles", RUN_CYCLES + 200);
    $display("Errors found");
    $finish;
  end

  function automatic string board_name(input int b);
    return (b == 0) ? "uut" : "peer";
  endfunction

  function automatic sync_link_pkg::cmd_data_t cmd_word(input logic en,
                                                        input sync_link_pkg::op_req_t op);
    sync_link_pkg::cmd_data_t w;
    w = '0;
    w[sync_link_pkg::ENABLE_BIT] = en;
    w[sync_link_pkg::OP_LSB +: 2] = op;
    return w;
  endfunction

  task automatic write_cmd(input int b, input logic en, input sync_link_pkg::op_req_t op);
    bus[b].rqst = 1'b1;
    bus[b].addr = sync_link_pkg::CMD_REG_ADDR;
    bus[b].data = cmd_word(en, op);
    @(negedge clk);
    bus[b].rqst = 1'b0;
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got == exp) else begin
      $display("FAILED %s: expected %h, got %h", name, exp, got);
      errors++;
    end
  endtask

  task automatic snapshot();
    for (int b = 0; b < 2; b++) begin
      base_nco[b] = nco_cnt[b];
      base_all[b] = all_cnt[b];
      base_to[b] = to_cnt[b];
      base_stall[b] = stall_cnt[b];
      base_tx[b] = tx_cnt[b];
    end
  endtask

  task automatic wait_stall(input int b, input logic level, input int limit);
    int n;
    n = 0;
    while (stall_req_w[b] !== level && n < limit) begin
      @(negedge clk);
      n++;
    end
    assert (stall_req_w[b] === level) else begin
      $display("%s stall_req did not go to %0b within %0d cycles", board_name(b), level, limit);
      errors++;
    end
  endtask

  task automatic report(input string name, input int errs_before);
    tests++;
    if (errors == errs_before) $display("%s: ok", name);
    else $display("%s: %0d errors", name, errors - errs_before);
  endtask

  task automatic run_handshake(input int from);
    int n;
    ack_delay[0] = $urandom % 21;
    ack_delay[1] = $urandom % 21;
    snapshot();
    write_cmd(from, 1'b1, sync_link_pkg::OP_STALL_ALL);
    n = 0;
    while ((all_cnt[0] == base_all[0] || all_cnt[1] == base_all[1] ||
            stall_req_w != 2'b00) && n < 180) begin
      @(negedge clk);
      n++;
    end
    assert (n < 180) else begin
      $display("handshake from %s did not finish within 180 cycles", board_name(from));
      errors++;
    end
    repeat (5) @(negedge clk);
    for (int b = 0; b < 2; b++) begin
      check_value({board_name(b), ".stall_req rose"}, 32'(stall_cnt[b] != base_stall[b]), 1);
      check_value({board_name(b), ".rst_all pulses"}, all_cnt[b] - base_all[b], 1);
      check_value({board_name(b), ".timeout pulses"}, to_cnt[b] - base_to[b], 0);
      check_value({board_name(b), ".stall_req"}, 32'(stall_req_w[b]), 0);
    end
  endtask

  task automatic test_reset_idle();
    int errs;
    errs = errors;
    for (int b = 0; b < 2; b++) begin
      check_value({board_name(b), ".linktx"}, 32'(tx_w[b]), 0);
      check_value({board_name(b), ".stall_req"}, 32'(stall_req_w[b]), 0);
      check_value({board_name(b), ".rst_all"}, 32'(rst_all_w[b]), 0);
      check_value({board_name(b), ".rst_nco"}, 32'(rst_nco_w[b]), 0);
      check_value({board_name(b), ".timeout"}, 32'(timeout_w[b]), 0);
    end
    snapshot();
    write_cmd(0, 1'b0, sync_link_pkg::OP_RST_NCO);
    write_cmd(0, 1'b0, sync_link_pkg::OP_STALL_ALL);
    write_cmd(1, 1'b0, sync_link_pkg::OP_STALL_ALL);
    repeat (20) @(negedge clk);
    for (int b = 0; b < 2; b++) begin
      check_value({board_name(b), ".linktx busy cycles"}, tx_cnt[b] - base_tx[b], 0);
      check_value({board_name(b), ".rst_nco pulses"}, nco_cnt[b] - base_nco[b], 0);
      check_value({board_name(b), ".stall_req cycles"}, stall_cnt[b] - base_stall[b], 0);
    end
    report("reset state and disabled writes", errs);
  endtask

  task automatic test_nco_request();
    int errs;
    int n;
    errs = errors;
    snapshot();
    write_cmd(0, 1'b1, sync_link_pkg::OP_RST_NCO);
    n = 0;
    while (nco_cnt[1] == base_nco[1] && n < 40) begin
      @(negedge clk);
      n++;
    end
    assert (n < 40) else begin
      $display("peer rst_nco did not pulse within 40 cycles of the request");
      errors++;
    end
    repeat (10) @(negedge clk);
    for (int b = 0; b < 2; b++) begin
      check_value({board_name(b), ".rst_nco pulses"}, nco_cnt[b] - base_nco[b], 1);
      check_value({board_name(b), ".rst_all pulses"}, all_cnt[b] - base_all[b], 0);
      check_value({board_name(b), ".stall_req cycles"}, stall_cnt[b] - base_stall[b], 0);
    end
    report("nco reset from uut", errs);
  endtask

  task automatic test_stall_timeout();
    int errs;
    int n;
    errs = errors;
    hold_ack[1] = 1'b1;
    ack_delay[0] = $urandom % 21;
    snapshot();
    write_cmd(0, 1'b1, sync_link_pkg::OP_STALL_ALL);
    n = 1;
    while (timeout_w[0] !== 1'b1 && n < 100) begin
      @(negedge clk);
      n++;
    end
    assert (n >= sync_link_pkg::HANDSHAKE_TIMEOUT && n <= sync_link_pkg::HANDSHAKE_TIMEOUT + 2)
    else begin
      $display("uut timeout came %0d cycles after the request, outside %0d to %0d", n,
               sync_link_pkg::HANDSHAKE_TIMEOUT, sync_link_pkg::HANDSHAKE_TIMEOUT + 2);
      errors++;
    end
    wait_stall(0, 1'b0, 4);
    wait_stall(1, 1'b0, 40);
    repeat (5) @(negedge clk);
    check_value("uut.rst_all pulses", all_cnt[0] - base_all[0], 0);
    check_value("uut.timeout pulses", to_cnt[0] - base_to[0], 1);
    hold_ack[1] = 1'b0;
    report("handshake abort on silent peer", errs);
  endtask

  task automatic test_disable_midway();
    int errs;
    errs = errors;
    hold_ack[1] = 1'b1;
    ack_delay[0] = $urandom % 21;
    write_cmd(0, 1'b1, sync_link_pkg::OP_STALL_ALL);
    wait_stall(1, 1'b1, 30);
    write_cmd(1, 1'b0, sync_link_pkg::OP_NONE);
    wait_stall(1, 1'b0, 4);
    write_cmd(0, 1'b0, sync_link_pkg::OP_NONE);
    wait_stall(0, 1'b0, 4);
    hold_ack[1] = 1'b0;
    write_cmd(0, 1'b1, sync_link_pkg::OP_NONE);
    write_cmd(1, 1'b1, sync_link_pkg::OP_NONE);
    run_handshake(1);
    report("disable mid-handshake and recover", errs);
  endtask

  initial begin
    int errs;
    void'($urandom(32'hcaf9_ff7f));
    errors = 0;
    tests = 0;
    arst_n = 1'b0;
    hold_ack = 2'b00;
    ack_delay[0] = 0;
    ack_delay[1] = 0;
    bus[0] = '0;
    bus[1] = '0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
    test_reset_idle();
    write_cmd(0, 1'b1, sync_link_pkg::OP_NONE);
    write_cmd(1, 1'b1, sync_link_pkg::OP_NONE);
    test_nco_request();
    errs = errors;
    run_handshake(0);
    report("stall handshake from uut", errs);
    errs = errors;
    run_handshake(1);
    report("stall handshake from peer", errs);
    test_stall_timeout();
    test_disable_midway();
    $display("tests run %0d, errors %0d", tests, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- rtl/sync_link_top.sv
`timescale 1ns/10ps
`default_nettype none

module sync_link_top (
  input  wire                             clk,
  input  wire                             arst_n,
  input  wire                             cmd_rqst,
  input  wire sync_link_pkg::cmd_addr_t   cmd_addr,
  input  wire sync_link_pkg::cmd_data_t   cmd_data,
  input  wire sync_link_pkg::link_pair_t  linkrx,
  output sync_link_pkg::link_pair_t       linktx,
  output logic                            stall_req,
  input  wire                             stall_ack,
  output logic                            rst_all,
  output logic                            rst_nco,
  output logic                            timeout
);

  logic                         enable;
  logic                         cmd_hit;
  sync_link_pkg::op_req_t       op_req;
  sync_link_pkg::link_stream_t  send_stream;
  sync_link_pkg::link_stream_t  recv_stream;
  logic                         send_ready;
  logic                         busy;
  logic                         progress;
  logic                         expired;
  logic                         rst_all_evt;
  logic                         rst_nco_evt;
  logic                         rst_all_p1;
  logic                         rst_nco_p1;

  assign cmd_hit = cmd_rqst && (cmd_addr == sync_link_pkg::CMD_REG_ADDR);
  assign op_req  = sync_link_pkg::op_req_t'(cmd_data[sync_link_pkg::OP_LSB +: 2]);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      enable <= 1'b0;
    end else if (cmd_hit) begin
      enable <= cmd_data[sync_link_pkg::ENABLE_BIT];
    end
  end

  // reset pulses leave through two register stages.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rst_all_p1 <= 1'b0;
      rst_nco_p1 <= 1'b0;
      rst_all    <= 1'b0;
      rst_nco    <= 1'b0;
    end else begin
      rst_all_p1 <= rst_all_evt;
      rst_nco_p1 <= rst_nco_evt;
      rst_all    <= rst_all_p1;
      rst_nco    <= rst_nco_p1;
    end
  end

  link_serializer u_ser (
    .clk         (clk),
    .arst_n      (arst_n),
    .enable      (enable),
    .send_stream (send_stream),
    .send_ready  (send_ready),
    .linktx      (linktx)
  );

  link_deserializer u_des (
    .clk         (clk),
    .arst_n      (arst_n),
    .enable      (enable),
    .linkrx      (linkrx),
    .recv_stream (recv_stream)
  );

  handshake_timer u_timer (
    .clk      (clk),
    .arst_n   (arst_n),
    .busy     (busy),
    .progress (progress),
    .expired  (expired)
  );

  sync_protocol_fsm u_fsm (
    .clk         (clk),
    .arst_n      (arst_n),
    .enable      (enable),
    .op_valid    (cmd_hit),
    .op_req      (op_req),
    .recv_stream (recv_stream),
    .send_stream (send_stream),
    .send_ready  (send_ready),
    .stall_req   (stall_req),
    .stall_ack   (stall_ack),
    .busy        (busy),
    .progress    (progress),
    .expired     (expired),
    .rst_all_evt (rst_all_evt),
    .rst_nco_evt (rst_nco_evt),
    .timeout     (timeout)
  );

endmodule

`default_nettype wire

//--- rtl/sync_protocol_fsm.sv
`timescale 1ns/10ps
`default_nettype none

module sync_protocol_fsm (
  input  wire                               clk,
  input  wire                               arst_n,
  input  wire                               enable,
  input  wire                               op_valid,
  input  wire sync_link_pkg::op_req_t       op_req,
  input  wire sync_link_pkg::link_stream_t  recv_stream,
  output sync_link_pkg::link_stream_t       send_stream,
  input  wire                               send_ready,
  output logic                              stall_req,
  input  wire                               stall_ack,
  output logic                              busy,
  output logic                              progress,
  input  wire                               expired,
  output logic                              rst_all_evt,
  output logic                              rst_nco_evt,
  output logic                              timeout
);

  sync_link_pkg::proto_state_t state;
  sync_link_pkg::proto_state_t state_next;
  sync_link_pkg::link_cmd_t    send_cmd_q;
  sync_link_pkg::link_cmd_t    load_cmd;
  logic                        send_valid_q;
  logic                        load;
  logic                        xfer;
  logic                        peer_ack_q;
  logic                        peer_ack;
  logic                        mst_rst_all;
  logic                        mst_rst_nco;
  logic                        slv_rst_all;
  logic                        slv_rst_nco;

  function automatic logic recv_is(sync_link_pkg::link_stream_t s,
                                   sync_link_pkg::link_cmd_t c);
    return s.valid && (s.cmd == c);
  endfunction

  assign send_stream = '{valid: send_valid_q, cmd: send_cmd_q};
  assign xfer        = send_valid_q && send_ready;

  // the peer's ack can come before our own stall is granted, so it is kept.
  assign peer_ack = peer_ack_q || recv_is(recv_stream, sync_link_pkg::CMD_STALL_ACK);

  assign busy      = (state != sync_link_pkg::MST_IDLE);
  assign progress  = (state_next != state);
  assign stall_req = busy && (state != sync_link_pkg::MST_RST_NCO);

  // slave role reacts to the peer's reset commands directly.
  assign slv_rst_nco = recv_is(recv_stream, sync_link_pkg::CMD_RST_NCO);
  assign slv_rst_all = recv_is(recv_stream, sync_link_pkg::CMD_RST_ALL);

  assign rst_all_evt = mst_rst_all || slv_rst_all;
  assign rst_nco_evt = mst_rst_nco || slv_rst_nco;

  always_comb begin
    state_next  = state;
    load        = 1'b0;
    load_cmd    = sync_link_pkg::CMD_NONE;
    mst_rst_all = 1'b0;
    mst_rst_nco = 1'b0;
    case (state)
      sync_link_pkg::MST_IDLE: begin
        if (op_valid && op_req == sync_link_pkg::OP_RST_NCO) begin
          load       = 1'b1;
          load_cmd   = sync_link_pkg::CMD_RST_NCO;
          state_next = sync_link_pkg::MST_RST_NCO;
        end else if (op_valid && op_req == sync_link_pkg::OP_STALL_ALL) begin
          load       = 1'b1;
          load_cmd   = sync_link_pkg::CMD_STALL_REQ;
          state_next = sync_link_pkg::MST_REQ_WAIT_ACK;
        end else if (recv_is(recv_stream, sync_link_pkg::CMD_STALL_REQ)) begin
          state_next = sync_link_pkg::MST_ACK_WAIT_LOCAL;
        end
      end
      sync_link_pkg::MST_RST_NCO: begin
        if (xfer) begin
          mst_rst_nco = 1'b1;
          state_next  = sync_link_pkg::MST_IDLE;
        end
      end
      sync_link_pkg::MST_REQ_WAIT_ACK: begin
        if (peer_ack && stall_ack && !send_valid_q) begin
          load       = 1'b1;
          load_cmd   = sync_link_pkg::CMD_RST_ALL;
          state_next = sync_link_pkg::MST_REQ_SEND_RST;
        end
      end
      sync_link_pkg::MST_REQ_SEND_RST: begin
        if (xfer) begin
          mst_rst_all = 1'b1;
          state_next  = sync_link_pkg::MST_REQ_WAIT_RLS;
        end
      end
      sync_link_pkg::MST_REQ_WAIT_RLS: begin
        if (recv_is(recv_stream, sync_link_pkg::CMD_STALL_RLS)) begin
          state_next = sync_link_pkg::MST_IDLE;
        end
      end
      sync_link_pkg::MST_ACK_WAIT_LOCAL: begin
        if (stall_ack && !send_valid_q) begin
          load       = 1'b1;
          load_cmd   = sync_link_pkg::CMD_STALL_ACK;
          state_next = sync_link_pkg::MST_ACK_WAIT_RST;
        end
      end
      sync_link_pkg::MST_ACK_WAIT_RST: begin
        if (recv_is(recv_stream, sync_link_pkg::CMD_RST_ALL)) begin
          load       = 1'b1;
          load_cmd   = sync_link_pkg::CMD_STALL_RLS;
          state_next = sync_link_pkg::MST_ACK_SEND_RLS;
        end
      end
      sync_link_pkg::MST_ACK_SEND_RLS: begin
        if (xfer) state_next = sync_link_pkg::MST_IDLE;
      end
      default: state_next = sync_link_pkg::MST_IDLE;
    endcase
    // a silent peer ends the handshake.
    if (expired) begin
      load       = 1'b0;
      state_next = sync_link_pkg::MST_IDLE;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state        <= sync_link_pkg::MST_IDLE;
      send_valid_q <= 1'b0;
      peer_ack_q   <= 1'b0;
      timeout      <= 1'b0;
    end else if (!enable) begin
      state        <= sync_link_pkg::MST_IDLE;
      send_valid_q <= 1'b0;
      peer_ack_q   <= 1'b0;
      timeout      <= 1'b0;
    end else begin
      state      <= state_next;
      timeout    <= expired;
      peer_ack_q <= peer_ack && (state_next == sync_link_pkg::MST_REQ_WAIT_ACK);
      if (load) begin
        send_valid_q <= 1'b1;
      end else if (xfer || expired) begin
        send_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (load) send_cmd_q <= load_cmd;
  end

endmodule

`default_nettype wire

//--- rtl/handshake_timer.sv
`timescale 1ns/10ps
`default_nettype none

module handshake_timer (
  input  wire  clk,
  input  wire  arst_n,
  input  wire  busy,
  input  wire  progress,
  output logic expired
);

  sync_link_pkg::timer_cnt_t count;

  assign expired = (count == sync_link_pkg::timer_cnt_t'(sync_link_pkg::HANDSHAKE_TIMEOUT));

  // counts idle cycles of an open handshake.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      count <= '0;
    end else if (!busy || progress || expired) begin
      count <= '0;
    end else begin
      count <= count + 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- rtl/link_deserializer.sv
`timescale 1ns/10ps
`default_nettype none

module link_deserializer (
  input  wire                               clk,
  input  wire                               arst_n,
  input  wire                               enable,
  input  wire sync_link_pkg::link_pair_t    linkrx,
  output sync_link_pkg::link_stream_t       recv_stream
);

  sync_link_pkg::des_state_t state;
  sync_link_pkg::link_pair_t rx_q;
  sync_link_pkg::link_pair_t hi_q;
  sync_link_pkg::link_cmd_t  cmd_q;
  logic                      valid_q;

  assign recv_stream = '{valid: valid_q, cmd: cmd_q};

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rx_q    <= sync_link_pkg::LINK_IDLE;
      state   <= sync_link_pkg::DES_IDLE;
      valid_q <= 1'b0;
    end else begin
      rx_q    <= linkrx;
      valid_q <= 1'b0;
      if (!enable) begin
        state <= sync_link_pkg::DES_IDLE;
      end else begin
        case (state)
          sync_link_pkg::DES_IDLE: begin
            if (rx_q == sync_link_pkg::LINK_START) state <= sync_link_pkg::DES_HI;
          end
          sync_link_pkg::DES_HI: state <= sync_link_pkg::DES_LO;
          sync_link_pkg::DES_LO: begin
            valid_q <= 1'b1;
            state   <= sync_link_pkg::DES_IDLE;
          end
          default: state <= sync_link_pkg::DES_IDLE;
        endcase
      end
    end
  end

  // the upper pair is held until the lower one arrives.
  always_ff @(posedge clk) begin
    if (state == sync_link_pkg::DES_HI) hi_q <= rx_q;
    if (state == sync_link_pkg::DES_LO) cmd_q <= sync_link_pkg::link_cmd_t'({hi_q, rx_q});
  end

endmodule

`default_nettype wire

//--- rtl/link_serializer.sv
`timescale 1ns/10ps
`default_nettype none

module link_serializer (
  input  wire                               clk,
  input  wire                               arst_n,
  input  wire                               enable,
  input  wire sync_link_pkg::link_stream_t  send_stream,
  output logic                              send_ready,
  output sync_link_pkg::link_pair_t         linktx
);

  sync_link_pkg::ser_state_t state;
  sync_link_pkg::ser_state_t state_next;
  sync_link_pkg::link_pair_t tx_next;
  sync_link_pkg::link_pair_t tx_q;
  sync_link_pkg::link_cmd_t  cmd_q;
  logic                      idle_q;

  // the second guard cycle ends one edge after the state machine is back in idle.
  assign send_ready = (state == sync_link_pkg::SER_IDLE) && idle_q;

  always_comb begin
    state_next = state;
    tx_next    = sync_link_pkg::LINK_IDLE;
    case (state)
      sync_link_pkg::SER_IDLE: begin
        if (send_stream.valid && send_ready) begin
          tx_next    = sync_link_pkg::LINK_START;
          state_next = sync_link_pkg::SER_HI;
        end
      end
      sync_link_pkg::SER_HI: begin
        tx_next    = cmd_q[3:2];
        state_next = sync_link_pkg::SER_LO;
      end
      sync_link_pkg::SER_LO: begin
        tx_next    = cmd_q[1:0];
        state_next = sync_link_pkg::SER_GUARD1;
      end
      // two idle symbols let the far receiver settle back to idle.
      sync_link_pkg::SER_GUARD1: state_next = sync_link_pkg::SER_GUARD2;
      sync_link_pkg::SER_GUARD2: state_next = sync_link_pkg::SER_IDLE;
      default: state_next = sync_link_pkg::SER_IDLE;
    endcase
  end

  // symbols pass one pipeline register before reaching the wire.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state  <= sync_link_pkg::SER_IDLE;
      tx_q   <= sync_link_pkg::LINK_IDLE;
      linktx <= sync_link_pkg::LINK_IDLE;
      idle_q <= 1'b1;
    end else if (!enable) begin
      state  <= sync_link_pkg::SER_IDLE;
      tx_q   <= sync_link_pkg::LINK_IDLE;
      linktx <= sync_link_pkg::LINK_IDLE;
      idle_q <= 1'b1;
    end else begin
      state  <= state_next;
      tx_q   <= tx_next;
      linktx <= tx_q;
      idle_q <= (state == sync_link_pkg::SER_IDLE);
    end
  end

  always_ff @(posedge clk) begin
    if (send_ready && send_stream.valid) begin
      cmd_q <= send_stream.cmd;
    end
  end

endmodule

`default_nettype wire

//--- rtl/sync_link_pkg.sv
`default_nettype none

package sync_link_pkg;

  // wire symbols; the line rests at idle between frames.
  typedef logic [1:0] link_pair_t;

  localparam link_pair_t LINK_IDLE  = 2'b00;
  localparam link_pair_t LINK_START = 2'b01;

  // command register on the strobe bus.
  typedef logic [5:0]  cmd_addr_t;
  typedef logic [31:0] cmd_data_t;

  localparam cmd_addr_t CMD_REG_ADDR = 6'h39;
  localparam int        ENABLE_BIT   = 31;
  localparam int        OP_LSB       = 24;

  // handshake abort limit in clock cycles.
  localparam int HANDSHAKE_TIMEOUT = 64;
  localparam int TIMER_W           = 7;

  typedef logic [TIMER_W-1:0] timer_cnt_t;

  typedef enum logic [3:0] {
    CMD_NONE      = 4'd0,
    CMD_STALL_REQ = 4'd1,
    CMD_STALL_ACK = 4'd2,
    CMD_STALL_RLS = 4'd3,
    CMD_RST_ALL   = 4'd4,
    CMD_RST_NCO   = 4'd5
  } link_cmd_t;

  typedef struct packed {
    logic      valid;
    link_cmd_t cmd;
  } link_stream_t;

  typedef enum logic [1:0] {
    OP_NONE      = 2'd0,
    OP_RST_NCO   = 2'd1,
    OP_STALL_ALL = 2'd2,
    OP_RSVD      = 2'd3
  } op_req_t;

  typedef enum logic [2:0] {
    MST_IDLE,
    MST_RST_NCO,
    MST_REQ_WAIT_ACK,
    MST_REQ_SEND_RST,
    MST_REQ_WAIT_RLS,
    MST_ACK_WAIT_LOCAL,
    MST_ACK_WAIT_RST,
    MST_ACK_SEND_RLS
  } proto_state_t;

  typedef enum logic [2:0] {
    SER_IDLE,
    SER_HI,
    SER_LO,
    SER_GUARD1,
    SER_GUARD2
  } ser_state_t;

  typedef enum logic [1:0] {
    DES_IDLE,
    DES_HI,
    DES_LO
  } des_state_t;

endpackage

`default_nettype wire
